//--- rv_core.f
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
`include "rv_core_defs.svh"

module rv_core_tb
  import rv_core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic                clk;
  logic                rst;
  logic                in_valid;
  instr_u              in_instr;
  logic [`RV_XLEN-1:0] in_pc;
  retire_t             retire;

  // Reference model state
  logic [`RV_XLEN-1:0] rf [`RV_NREGS];
  logic [`RV_XLEN-1:0] mstatus_m;
  logic [`RV_XLEN-1:0] mtvec_m;
  logic [`RV_XLEN-1:0] mscratch_m;
  logic [`RV_XLEN-1:0] mepc_m;
  logic [`RV_XLEN-1:0] mcause_m;
  logic [`RV_XLEN-1:0] next_pc;
  retire_t             exp_q [$];
  string               test_name;
  int                  seed;

  rv_core dut_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_pc    (in_pc),
    .retire   (retire)
  );

  bind rv_core rv_core_asserts asserts_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_pc    (in_pc),
    .retire   (retire)
  );

  always #10 clk = ~clk;

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  function automatic logic [31:0] read_csr(input logic [11:0] addr);
    case (addr)
      `RV_CSR_MSTATUS:  return mstatus_m;
      `RV_CSR_MTVEC:    return mtvec_m;
      `RV_CSR_MSCRATCH: return mscratch_m;
      `RV_CSR_MEPC:     return mepc_m;
      `RV_CSR_MCAUSE:   return mcause_m;
      default:          return '0;
    endcase
  endfunction

  function automatic void write_csr(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      `RV_CSR_MSTATUS:  mstatus_m  = val;
      `RV_CSR_MTVEC:    mtvec_m    = val;
      `RV_CSR_MSCRATCH: mscratch_m = val;
      `RV_CSR_MEPC:     mepc_m     = val;
      `RV_CSR_MCAUSE:   mcause_m   = val;
      default:          ;
    endcase
  endfunction

  function automatic logic [31:0] encode(input op_e op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [31:0] imm, input logic [11:0] csr);
    case (op)
      OP_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      OP_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      OP_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      OP_LUI:   return {imm[19:0], rd, 7'b0110111};
      OP_CSRRW: return {csr, rs1, 3'b001, rd, 7'b1110011};
      OP_CSRRS: return {csr, rs1, 3'b010, rd, 7'b1110011};
      OP_ECALL: return 32'h0000_0073;
      default:  return {imm[11:0], rs1, 3'b010, rd, 7'b0000011}; // LW, not supported
    endcase
  endfunction

  // Sequential ISA semantics, one instruction at a time
  function automatic retire_t predict(input op_e op, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [4:0] rs2,
                                      input logic [31:0] imm, input logic [11:0] csr,
                                      input logic [31:0] pc);
    retire_t     r;
    logic        writes;
    logic [31:0] old;
    r.valid = 1'b1;
    r.pc    = pc;
    r.rd    = rd;
    r.data  = '0;
    writes  = 1'b1;
    case (op)
      OP_ADD:   r.data = rf[rs1] + rf[rs2];
      OP_SUB:   r.data = rf[rs1] - rf[rs2];
      OP_ADDI:  r.data = rf[rs1] + {{20{imm[11]}}, imm[11:0]};
      OP_LUI:   r.data = {imm[19:0], 12'h000};
      OP_CSRRW: begin
        old    = read_csr(csr);
        r.data = old;
        write_csr(csr, rf[rs1]);
      end
      OP_CSRRS: begin
        old    = read_csr(csr);
        r.data = old;
        if (rs1 != 5'd0) begin
          write_csr(csr, old | rf[rs1]);
        end
      end
      OP_ECALL: begin
        writes   = 1'b0;
        mepc_m   = pc;
        mcause_m = `RV_CAUSE_ECALL;
      end
      default:  writes = 1'b0;
    endcase
    r.rd_we = writes && (rd != 5'd0);
    if (r.rd_we) begin
      rf[rd] = r.data;
    end
    return r;
  endfunction

  task automatic send(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [31:0] imm, input logic [11:0] csr);
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    in_instr = encode(op, rd, rs1, rs2, imm, csr);
    in_pc    = next_pc;
    exp_q.push_back(predict(op, rd, rs1, rs2, imm, csr, next_pc));
    next_pc  = next_pc + 32'd4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    idle(1);
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_fail($sformatf("Timeout in %s: no instruction retired", test_name));
    end
  endtask

  task automatic check_field(input string field, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val)
      else report_fail($sformatf("Fail %s %s: expected %h, actual %h",
                                 test_name, field, exp_val, act_val));
  endtask

  // Compare on the falling edge, away from the retire register update
  always @(negedge clk) begin
    retire_t exp;
    if (dut_i.asserts_i.err_count != 0) begin
      report_fail("A concurrent assertion on the DUT failed");
    end
    if (!rst && retire.valid) begin
      if (exp_q.size() == 0) begin
        report_fail("The DUT retired an instruction that was never issued");
      end else begin
        exp = exp_q.pop_front();
        check_field("pc", exp.pc, retire.pc);
        check_field("rd_we", 32'(exp.rd_we), 32'(retire.rd_we));
        check_field("rd", 32'(exp.rd), 32'(retire.rd));
        check_field("data", exp.data, retire.data);
      end
    end
  end

  initial begin
    op_e op;
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_instr   = '0;
    in_pc      = '0;
    seed       = $urandom(76);
    next_pc    = 32'h0000_1000;
    mstatus_m  = `RV_MSTATUS_RESET;
    mtvec_m    = '0;
    mscratch_m = '0;
    mepc_m     = '0;
    mcause_m   = '0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      rf[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "reset_values";
    send(OP_CSRRS, 5'd3, 5'd0, 5'd0, '0, `RV_CSR_MSTATUS);
    send(OP_ADD, 5'd4, 5'd1, 5'd2, '0, '0);
    drain();

    test_name = "dependent_chain";
    send(OP_LUI, 5'd5, 5'd0, 5'd0, 32'h12345, '0);
    send(OP_ADDI, 5'd6, 5'd5, 5'd0, 32'h678, '0);
    send(OP_ADD, 5'd7, 5'd6, 5'd5, '0, '0);
    send(OP_SUB, 5'd8, 5'd7, 5'd6, '0, '0);
    send(OP_ADDI, 5'd9, 5'd8, 5'd0, 32'hfff, '0); // -1
    drain();

    test_name = "x0_rules";
    send(OP_ADDI, 5'd0, 5'd5, 5'd0, 32'd100, '0);
    send(OP_ADD, 5'd10, 5'd0, 5'd0, '0, '0);
    send(OP_ADD, 5'd11, 5'd0, 5'd5, '0, '0);
    drain();

    test_name = "csr_access";
    send(OP_LUI, 5'd12, 5'd0, 5'd0, 32'habcde, '0);
    send(OP_ADDI, 5'd12, 5'd12, 5'd0, 32'h123, '0);
    send(OP_CSRRW, 5'd13, 5'd12, 5'd0, '0, `RV_CSR_MSCRATCH);
    send(OP_CSRRS, 5'd14, 5'd0, 5'd0, '0, `RV_CSR_MSCRATCH);
    send(OP_CSRRW, 5'd15, 5'd12, 5'd0, '0, 12'h7c0);
    send(OP_CSRRS, 5'd16, 5'd0, 5'd0, '0, 12'h7c0);
    send(OP_CSRRS, 5'd17, 5'd12, 5'd0, '0, `RV_CSR_MTVEC);
    send(OP_CSRRS, 5'd18, 5'd0, 5'd0, '0, `RV_CSR_MTVEC);
    drain();

    test_name = "ecall_and_unknown";
    send(OP_ECALL, 5'd0, 5'd0, 5'd0, '0, '0);
    send(OP_CSRRS, 5'd19, 5'd0, 5'd0, '0, `RV_CSR_MEPC);
    send(OP_CSRRS, 5'd20, 5'd0, 5'd0, '0, `RV_CSR_MCAUSE);
    send(OP_NOP, 5'd21, 5'd19, 5'd0, 32'h10, '0);
    send(OP_ADD, 5'd22, 5'd21, 5'd20, '0, '0);
    drain();

    test_name = "random_alu";
    for (int i = 0; i < 200; i++) begin
      case ($urandom_range(3, 0))
        0:       op = OP_ADD;
        1:       op = OP_SUB;
        2:       op = OP_ADDI;
        default: op = OP_LUI;
      endcase
      send(op, 5'($urandom), 5'($urandom), 5'($urandom), $urandom, '0);
      if ($urandom_range(3, 0) == 0) begin
        idle($urandom_range(3, 1));
      end
    end
    drain();

    if (dut_i.asserts_i.err_count != 0) begin
      report_fail("A concurrent assertion on the DUT failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- tb/rv_core_asserts.sv
`include "rv_core_defs.svh"

module rv_core_asserts
  import rv_core_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                in_valid,
  input logic [`RV_XLEN-1:0] in_pc,
  input retire_t             retire
);

  timeunit 1ns;
  timeprecision 1ps;

  int err_count = 0; // Failures seen so far

  retire_low_after_rst: assert property (@(posedge clk) rst |=> !retire.valid)
    else begin
      err_count++;
      $error("retire.valid is high in the cycle after reset");
    end

  // Decode, execute and writeback each add one edge
  retire_latency: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> ##3 retire.valid)
    else begin
      err_count++;
      $error("retire.valid did not follow in_valid by three cycles");
    end

  retire_pc_match: assert property (@(posedge clk) disable iff (rst)
    retire.valid |-> $past(in_valid, 3) && retire.pc == $past(in_pc, 3))
    else begin
      err_count++;
      $error("retired instruction has no matching in_valid and pc three cycles earlier");
    end

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    !(retire.rd_we && retire.rd == 5'd0))
    else begin
      err_count++;
      $error("retire reports a write to x0");
    end

endmodule

//--- hw/rv_core.sv
`include "rv_core_defs.svh"

module rv_core
  import rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  instr_u              in_instr,
  input  logic [`RV_XLEN-1:0] in_pc,
  output retire_t             retire
);

  dec_t                dec;
  ex_t                 ex;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [11:0]         csr_raddr;
  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;
  logic [`RV_XLEN-1:0] csr_rdata;

  rv_decode decode_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_pc    (in_pc),
    .dec      (dec)
  );

  // Operand reads loop back from writeback in the same cycle
  rv_execute execute_i (
    .clk       (clk),
    .rst       (rst),
    .dec       (dec),
    .rs1       (rs1),
    .rs2       (rs2),
    .csr_raddr (csr_raddr),
    .src1      (src1),
    .src2      (src2),
    .csr_rdata (csr_rdata),
    .ex        (ex)
  );

  rv_writeback writeback_i (
    .clk       (clk),
    .rst       (rst),
    .rs1       (rs1),
    .rs2       (rs2),
    .csr_raddr (csr_raddr),
    .src1      (src1),
    .src2      (src2),
    .csr_rdata (csr_rdata),
    .ex        (ex),
    .retire    (retire)
  );

endmodule

//--- hw/rv_writeback.sv
`include "rv_core_defs.svh"

module rv_writeback
  import rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  logic [11:0]         csr_raddr,
  output logic [`RV_XLEN-1:0] src1,
  output logic [`RV_XLEN-1:0] src2,
  output logic [`RV_XLEN-1:0] csr_rdata,
  input  ex_t                 ex,
  output retire_t             retire
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  logic [`RV_XLEN-1:0] mstatus;
  logic [`RV_XLEN-1:0] mtvec;
  logic [`RV_XLEN-1:0] mscratch;
  logic [`RV_XLEN-1:0] mepc;
  logic [`RV_XLEN-1:0] mcause;

  logic [`RV_XLEN-1:0] mstatus_n;
  logic [`RV_XLEN-1:0] mtvec_n;
  logic [`RV_XLEN-1:0] mscratch_n;
  logic [`RV_XLEN-1:0] mepc_n;
  logic [`RV_XLEN-1:0] mcause_n;

  logic    reg_wr;
  retire_t retire_d;

  assign reg_wr = ex.valid && ex.rd_we && (ex.rd != 5'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr) begin
      regs[ex.rd] <= ex.result;
    end
  end

  // Write-through on a match with the committing rd
  assign src1 = (rs1 == 5'd0) ? '0 : (reg_wr && ex.rd == rs1) ? ex.result : regs[rs1];
  assign src2 = (rs2 == 5'd0) ? '0 : (reg_wr && ex.rd == rs2) ? ex.result : regs[rs2];

  // Next CSR state, also the write-through source
  always_comb begin
    mstatus_n  = mstatus;
    mtvec_n    = mtvec;
    mscratch_n = mscratch;
    mepc_n     = mepc;
    mcause_n   = mcause;
    if (ex.valid && ex.csr_we) begin
      case (ex.csr_waddr)
        `RV_CSR_MSTATUS:  mstatus_n  = ex.csr_wdata;
        `RV_CSR_MTVEC:    mtvec_n    = ex.csr_wdata;
        `RV_CSR_MSCRATCH: mscratch_n = ex.csr_wdata;
        `RV_CSR_MEPC:     mepc_n     = ex.csr_wdata;
        `RV_CSR_MCAUSE:   mcause_n   = ex.csr_wdata;
        default:          ; // Unimplemented CSRs ignore writes
      endcase
    end
    if (ex.valid && ex.ecall) begin
      mepc_n   = ex.pc;
      mcause_n = `RV_CAUSE_ECALL;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= `RV_MSTATUS_RESET;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else begin
      mstatus  <= mstatus_n;
      mtvec    <= mtvec_n;
      mscratch <= mscratch_n;
      mepc     <= mepc_n;
      mcause   <= mcause_n;
    end
  end

  always_comb begin
    case (csr_raddr)
      `RV_CSR_MSTATUS:  csr_rdata = mstatus_n;
      `RV_CSR_MTVEC:    csr_rdata = mtvec_n;
      `RV_CSR_MSCRATCH: csr_rdata = mscratch_n;
      `RV_CSR_MEPC:     csr_rdata = mepc_n;
      `RV_CSR_MCAUSE:   csr_rdata = mcause_n;
      default:          csr_rdata = '0;
    endcase
  end

  always_comb begin
    retire_d.valid = ex.valid;
    retire_d.pc    = ex.pc;
    retire_d.rd    = ex.rd;
    retire_d.rd_we = reg_wr;
    retire_d.data  = ex.result;
  end

  always_ff @(posedge clk) begin
    retire <= retire_d;
    if (rst) begin
      retire.valid <= 1'b0;
    end
  end

endmodule

//--- hw/rv_execute.sv
`include "rv_core_defs.svh"

module rv_execute
  import rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  dec_t                dec,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [11:0]         csr_raddr,
  input  logic [`RV_XLEN-1:0] src1,
  input  logic [`RV_XLEN-1:0] src2,
  input  logic [`RV_XLEN-1:0] csr_rdata,
  output ex_t                 ex
);

  logic writes_rd;
  logic writes_csr;
  ex_t  ex_d;

  // Operand reads go straight to the writeback read ports
  assign rs1       = dec.rs1;
  assign rs2       = dec.rs2;
  assign csr_raddr = dec.csr_addr;

  always_comb begin
    writes_rd      = 1'b0;
    writes_csr     = 1'b0;
    ex_d.valid     = dec.valid;
    ex_d.pc        = dec.pc;
    ex_d.rd        = dec.rd;
    ex_d.result    = '0;
    ex_d.csr_waddr = dec.csr_addr;
    ex_d.csr_wdata = '0;
    ex_d.ecall     = 1'b0;
    case (dec.op)
      OP_ADD: begin
        writes_rd   = 1'b1;
        ex_d.result = src1 + src2;
      end
      OP_SUB: begin
        writes_rd   = 1'b1;
        ex_d.result = src1 - src2;
      end
      OP_ADDI: begin
        writes_rd   = 1'b1;
        ex_d.result = src1 + dec.imm;
      end
      OP_LUI: begin
        writes_rd   = 1'b1;
        ex_d.result = dec.imm;
      end
      OP_CSRRW: begin
        writes_rd      = 1'b1;
        writes_csr     = 1'b1;
        ex_d.result    = csr_rdata;
        ex_d.csr_wdata = src1;
      end
      OP_CSRRS: begin
        writes_rd      = 1'b1;
        writes_csr     = (dec.rs1 != 5'd0); // rs1 of x0 is a pure read
        ex_d.result    = csr_rdata;
        ex_d.csr_wdata = csr_rdata | src1;
      end
      OP_ECALL: begin
        ex_d.ecall = dec.valid;
      end
      default: begin
        writes_rd = 1'b0;
      end
    endcase
    ex_d.rd_we  = dec.valid && writes_rd && (dec.rd != 5'd0);
    ex_d.csr_we = dec.valid && writes_csr;
  end

  always_ff @(posedge clk) begin
    ex <= ex_d;
    if (rst) begin
      ex.valid <= 1'b0;
    end
  end

endmodule

//--- hw/rv_decode.sv
`include "rv_core_defs.svh"

module rv_decode
  import rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  instr_u              in_instr,
  input  logic [`RV_XLEN-1:0] in_pc,
  output dec_t                dec
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_PRIV  = 3'b000;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  op_e                 op;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  dec_t                dec_d;

  always_comb begin
    op = OP_NOP;
    case (in_instr.r_fmt.opcode)
      OPC_OP: begin
        if (in_instr.r_fmt.funct3 == F3_ADD) begin
          if (in_instr.r_fmt.funct7 == F7_ADD) begin
            op = OP_ADD;
          end else if (in_instr.r_fmt.funct7 == F7_SUB) begin
            op = OP_SUB;
          end
        end
      end
      OPC_OPIMM: begin
        if (in_instr.i_fmt.funct3 == F3_ADD) begin
          op = OP_ADDI;
        end
      end
      OPC_LUI: begin
        op = OP_LUI;
      end
      OPC_SYSTEM: begin
        case (in_instr.i_fmt.funct3)
          F3_PRIV: begin
            // ECALL is the all-zero PRIV encoding
            if (in_instr.i_fmt.imm12 == 12'h000 &&
                in_instr.i_fmt.rs1 == 5'd0 &&
                in_instr.i_fmt.rd == 5'd0) begin
              op = OP_ECALL;
            end
          end
          F3_CSRRW: begin
            op = OP_CSRRW;
          end
          F3_CSRRS: begin
            op = OP_CSRRS;
          end
          default: begin
            op = OP_NOP;
          end
        endcase
      end
      default: begin
        op = OP_NOP;
      end
    endcase
  end

  assign imm_i = {{(`RV_XLEN-12){in_instr.i_fmt.imm12[11]}}, in_instr.i_fmt.imm12};
  assign imm_u = {in_instr.u_fmt.imm20, 12'h000};

  always_comb begin
    dec_d.valid    = in_valid;
    dec_d.pc       = in_pc;
    dec_d.op       = op;
    dec_d.rd       = in_instr.r_fmt.rd;
    dec_d.rs1      = in_instr.r_fmt.rs1;
    dec_d.rs2      = in_instr.r_fmt.rs2;
    dec_d.imm      = (op == OP_LUI) ? imm_u : imm_i;
    dec_d.csr_addr = in_instr.i_fmt.imm12;
  end

  always_ff @(posedge clk) begin
    dec <= dec_d;
    if (rst) begin
      dec.valid <= 1'b0;
    end
  end

endmodule

//--- hw/rv_core_pkg.sv
`include "rv_core_defs.svh"

package rv_core_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12; // CSR address for SYSTEM ops
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One instruction word, three format views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_ADDI,
    OP_LUI,
    OP_CSRRW,
    OP_CSRRS,
    OP_ECALL,
    OP_NOP
  } op_e;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    op_e                 op;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] imm;
    logic [11:0]         csr_addr;
  } dec_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rd;
    logic                rd_we;
    logic [`RV_XLEN-1:0] result;
    logic                csr_we;
    logic [11:0]         csr_waddr;
    logic [`RV_XLEN-1:0] csr_wdata;
    logic                ecall; // Writes mepc and mcause together
  } ex_t;

  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rd;
    logic                rd_we;
    logic [`RV_XLEN-1:0] data;
  } retire_t;

endpackage

//--- hw/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath and register file
`define RV_XLEN          32
`define RV_NREGS         32

// Implemented machine CSR addresses
`define RV_CSR_MSTATUS   12'h300
`define RV_CSR_MTVEC     12'h305
`define RV_CSR_MSCRATCH  12'h340
`define RV_CSR_MEPC      12'h341
`define RV_CSR_MCAUSE    12'h342

// MPP field set to machine mode
`define RV_MSTATUS_RESET 32'h0000_1800

// Environment call from M-mode
`define RV_CAUSE_ECALL   32'd11

`endif
